// ==== design/core_pkg.sv ====
/*
 * Shared constants of the in-order integer core.
 * Widths, fetch queue sizing and the RV32I opcode and funct codes of the
 * supported ALU subset. Modules pull these in with a wildcard import.
 */

`default_nettype none

package core_pkg;

    // datapath and instruction widths
    localparam int xlen = 32;
    localparam int ilen = 32;

    // fetch queue sizing, pointer width is log2 of the depth
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = 2;

    // architectural registers
    localparam int nregs      = 32;
    localparam int reg_addr_w = 5;

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    // funct3 of the supported operations
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // funct7 that turns ADD into SUB
    localparam logic [6:0] f7_sub = 7'b0100000;

endpackage

`default_nettype wire

// ==== design/instr_fetch.sv ====
/*
 * Instruction fetch unit.
 * Issues sequential word requests on the req/gnt/rvalid instruction port
 * and forwards each returned word with its PC to the fetch queue. Requests
 * are throttled so that every outstanding response has a queue slot.
 */

`timescale 1ns/100ps
`default_nettype none

module instr_fetch
    import core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  fetch_enable_i,
    input  logic [xlen-1:0]       boot_addr_i,
    output logic                  instr_req_o,
    output logic [xlen-1:0]       instr_addr_o,
    input  logic                  instr_gnt_i,
    input  logic                  instr_rvalid_i,
    input  logic [ilen-1:0]       instr_rdata_i,
    input  logic [fifo_ptr_w:0]   fifo_count_i,
    output logic                  push_o,
    output logic [ilen-1:0]       push_data_o,
    output logic [xlen-1:0]       push_pc_o,
    output logic                  busy_o
);

    logic                  req_q;
    logic                  started_q;
    logic [xlen-1:0]       addr_q;
    logic [fifo_ptr_w:0]   outstanding_q;
    logic                  accept;
    logic [fifo_ptr_w+1:0] slots_used;
    logic                  room;

    // PCs of accepted requests, in request order
    logic [xlen-1:0]       pc_q [fifo_depth];
    logic [fifo_ptr_w-1:0] pc_wr_ptr_q;
    logic [fifo_ptr_w-1:0] pc_rd_ptr_q;

    assign accept = req_q & instr_gnt_i;

    // slots taken next cycle, pops ignored so the estimate never runs short
    assign slots_used = {1'b0, outstanding_q}
                      + {1'b0, fifo_count_i}
                      + {{(fifo_ptr_w+1){1'b0}}, accept};
    assign room = slots_used < (fifo_ptr_w+2)'(fifo_depth);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_q         <= 1'b0;
            started_q     <= 1'b0;
            outstanding_q <= '0;
            pc_wr_ptr_q   <= '0;
            pc_rd_ptr_q   <= '0;
        end else begin
            started_q <= started_q | fetch_enable_i;
            // an ungranted request holds, a new one needs enable and room
            req_q <= (req_q & ~instr_gnt_i) | (fetch_enable_i & room);

            case ({accept, instr_rvalid_i})
                2'b10:   outstanding_q <= outstanding_q + 1'b1;
                2'b01:   outstanding_q <= outstanding_q - 1'b1;
                default: outstanding_q <= outstanding_q;
            endcase

            if (accept) begin
                pc_wr_ptr_q <= pc_wr_ptr_q + 1'b1;
            end
            if (instr_rvalid_i) begin
                pc_rd_ptr_q <= pc_rd_ptr_q + 1'b1;
            end
        end
    end

    // address follows boot_addr_i until fetching starts
    always_ff @(posedge clk_i) begin
        if (!started_q) begin
            addr_q <= boot_addr_i;
        end else if (accept) begin
            addr_q <= addr_q + xlen'(4);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            pc_q[pc_wr_ptr_q] <= addr_q;
        end
    end

    assign instr_req_o  = req_q;
    assign instr_addr_o = addr_q;

    // responses go straight into the queue
    assign push_o      = instr_rvalid_i;
    assign push_data_o = instr_rdata_i;
    assign push_pc_o   = pc_q[pc_rd_ptr_q];

    assign busy_o = req_q | (outstanding_q != '0);

endmodule

`default_nettype wire

// ==== design/fetch_fifo.sv ====
/*
 * Fetch queue between the fetch unit and the execute stage.
 * Circular buffer of instruction word and PC pairs, read in order.
 * The fetch unit guarantees room, so there is no full indication.
 */

`timescale 1ns/100ps
`default_nettype none

module fetch_fifo
    import core_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                push_i,
    input  logic [ilen-1:0]     push_data_i,
    input  logic [xlen-1:0]     push_pc_i,
    input  logic                pop_i,
    output logic                empty_o,
    output logic [fifo_ptr_w:0] count_o,
    output logic [ilen-1:0]     head_data_o,
    output logic [xlen-1:0]     head_pc_o
);

    logic [ilen-1:0]       data_q [fifo_depth];
    logic [xlen-1:0]       pc_q   [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr_q;
    logic [fifo_ptr_w-1:0] rd_ptr_q;
    logic [fifo_ptr_w:0]   count_q;
    logic                  do_pop;

    assign empty_o = (count_q == '0);
    // a pop on an empty queue is dropped
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            data_q[wr_ptr_q] <= push_data_i;
            pc_q[wr_ptr_q]   <= push_pc_i;
        end
    end

    assign count_o     = count_q;
    assign head_data_o = data_q[rd_ptr_q];
    assign head_pc_o   = pc_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
/*
 * Integer register file, 32 entries of xlen bits.
 * Two combinational read ports and one synchronous write port.
 * x0 reads as zero and ignores writes.
 */

`timescale 1ns/100ps
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [reg_addr_w-1:0] rs1_i,
    input  logic [reg_addr_w-1:0] rs2_i,
    input  logic                  we_i,
    input  logic [reg_addr_w-1:0] rd_i,
    input  logic [xlen-1:0]       wdata_i,
    output logic [xlen-1:0]       rs1_data_o,
    output logic [xlen-1:0]       rs2_data_o
);

    logic [xlen-1:0] regs_q [nregs];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < nregs; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    // x0 forced to zero on read as well
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

`default_nettype wire

// ==== design/alu_exec.sv ====
/*
 * Execute stage for the supported RV32I ALU subset.
 * Decodes the queue head, reads operands, writes the result back as the
 * head is popped and registers the commit trace one clock later.
 * Any other word retires as a no-op with rd and wdata zero.
 */

`timescale 1ns/100ps
`default_nettype none

module alu_exec
    import core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  empty_i,
    input  logic [ilen-1:0]       head_data_i,
    input  logic [xlen-1:0]       head_pc_i,
    output logic                  pop_o,
    output logic [reg_addr_w-1:0] rs1_o,
    output logic [reg_addr_w-1:0] rs2_o,
    input  logic [xlen-1:0]       rs1_data_i,
    input  logic [xlen-1:0]       rs2_data_i,
    output logic                  we_o,
    output logic [reg_addr_w-1:0] rd_o,
    output logic [xlen-1:0]       wdata_o,
    output logic                  commit_valid_o,
    output logic [xlen-1:0]       commit_pc_o,
    output logic [reg_addr_w-1:0] commit_rd_o,
    output logic [xlen-1:0]       commit_wdata_o,
    output logic                  busy_o
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
    logic                  is_imm;
    logic                  f7_ok;
    logic [xlen-1:0]       operand_b;
    logic [xlen-1:0]       result;
    logic                  supported;

    logic                  commit_valid_q;
    logic [xlen-1:0]       commit_pc_q;
    logic [reg_addr_w-1:0] commit_rd_q;
    logic [xlen-1:0]       commit_wdata_q;

    // instruction fields
    assign opcode = head_data_i[6:0];
    assign rd     = head_data_i[11:7];
    assign funct3 = head_data_i[14:12];
    assign rs1_o  = head_data_i[19:15];
    assign rs2_o  = head_data_i[24:20];
    assign funct7 = head_data_i[31:25];
    assign imm    = {{(xlen-12){head_data_i[31]}}, head_data_i[31:20]};

    assign is_imm    = (opcode == opc_op_imm);
    // register form needs funct7 zero, except SUB
    assign f7_ok     = is_imm || (funct7 == 7'b0);
    assign operand_b = is_imm ? imm : rs2_data_i;

    always_comb begin
        supported = 1'b0;
        result    = '0;
        if ((opcode == opc_op) || is_imm) begin
            case (funct3)
                f3_add: begin
                    if (f7_ok) begin
                        supported = 1'b1;
                        result    = rs1_data_i + operand_b;
                    end else if (funct7 == f7_sub) begin
                        supported = 1'b1;
                        result    = rs1_data_i - operand_b;
                    end
                end
                f3_xor: begin
                    supported = f7_ok;
                    result    = rs1_data_i ^ operand_b;
                end
                f3_or: begin
                    supported = f7_ok;
                    result    = rs1_data_i | operand_b;
                end
                f3_and: begin
                    supported = f7_ok;
                    result    = rs1_data_i & operand_b;
                end
                default: begin
                    supported = 1'b0;
                    result    = '0;
                end
            endcase
        end
    end

    // head consumed every cycle it is valid
    assign pop_o   = ~empty_i;
    assign we_o    = pop_o & supported;
    assign rd_o    = rd;
    assign wdata_o = result;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= pop_o;
        end
    end

    // trace reports wdata zero whenever nothing is written, x0 included
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            commit_pc_q    <= head_pc_i;
            commit_rd_q    <= supported ? rd : '0;
            commit_wdata_q <= (supported && (rd != '0)) ? result : '0;
        end
    end

    assign commit_valid_o = commit_valid_q;
    assign commit_pc_o    = commit_pc_q;
    assign commit_rd_o    = commit_rd_q;
    assign commit_wdata_o = commit_wdata_q;

    assign busy_o = pop_o | commit_valid_q;

endmodule

`default_nettype wire

// ==== design/core_top.sv ====
/*
 * Top level of the minimal integer core.
 * Connects fetch unit, fetch queue, execute stage and register file.
 * Exposes the instruction port and a commit trace of retired instructions.
 */

`timescale 1ns/100ps
`default_nettype none

module core_top
    import core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  fetch_enable_i,
    input  logic [xlen-1:0]       boot_addr_i,
    output logic                  instr_req_o,
    output logic [xlen-1:0]       instr_addr_o,
    input  logic                  instr_gnt_i,
    input  logic                  instr_rvalid_i,
    input  logic [ilen-1:0]       instr_rdata_i,
    output logic                  commit_valid_o,
    output logic [xlen-1:0]       commit_pc_o,
    output logic [reg_addr_w-1:0] commit_rd_o,
    output logic [xlen-1:0]       commit_wdata_o,
    output logic                  core_busy_o
);

    logic                  push;
    logic [ilen-1:0]       push_data;
    logic [xlen-1:0]       push_pc;
    logic                  pop;
    logic                  fifo_empty;
    logic [fifo_ptr_w:0]   fifo_count;
    logic [ilen-1:0]       head_data;
    logic [xlen-1:0]       head_pc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_rd;
    logic [xlen-1:0]       rf_wdata;
    logic                  fetch_busy;
    logic                  exec_busy;

    instr_fetch i_fetch (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .boot_addr_i    ( boot_addr_i    ),
        .instr_req_o    ( instr_req_o    ),
        .instr_addr_o   ( instr_addr_o   ),
        .instr_gnt_i    ( instr_gnt_i    ),
        .instr_rvalid_i ( instr_rvalid_i ),
        .instr_rdata_i  ( instr_rdata_i  ),
        .fifo_count_i   ( fifo_count     ),
        .push_o         ( push           ),
        .push_data_o    ( push_data      ),
        .push_pc_o      ( push_pc        ),
        .busy_o         ( fetch_busy     )
    );

    fetch_fifo i_fifo (
        .clk_i       ( clk_i      ),
        .rst_n_i     ( rst_n_i    ),
        .push_i      ( push       ),
        .push_data_i ( push_data  ),
        .push_pc_i   ( push_pc    ),
        .pop_i       ( pop        ),
        .empty_o     ( fifo_empty ),
        .count_o     ( fifo_count ),
        .head_data_o ( head_data  ),
        .head_pc_o   ( head_pc    )
    );

    alu_exec i_exec (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .empty_i        ( fifo_empty     ),
        .head_data_i    ( head_data      ),
        .head_pc_i      ( head_pc        ),
        .pop_o          ( pop            ),
        .rs1_o          ( rs1            ),
        .rs2_o          ( rs2            ),
        .rs1_data_i     ( rs1_data       ),
        .rs2_data_i     ( rs2_data       ),
        .we_o           ( rf_we          ),
        .rd_o           ( rf_rd          ),
        .wdata_o        ( rf_wdata       ),
        .commit_valid_o ( commit_valid_o ),
        .commit_pc_o    ( commit_pc_o    ),
        .commit_rd_o    ( commit_rd_o    ),
        .commit_wdata_o ( commit_wdata_o ),
        .busy_o         ( exec_busy      )
    );

    reg_file i_regs (
        .clk_i      ( clk_i    ),
        .rst_n_i    ( rst_n_i  ),
        .rs1_i      ( rs1      ),
        .rs2_i      ( rs2      ),
        .we_i       ( rf_we    ),
        .rd_i       ( rf_rd    ),
        .wdata_i    ( rf_wdata ),
        .rs1_data_o ( rs1_data ),
        .rs2_data_o ( rs2_data )
    );

    // busy while anything is in flight anywhere in the pipe
    assign core_busy_o = fetch_busy | exec_busy;

endmodule

`default_nettype wire

// ==== dv/imem_responder.sv ====
/*
 * Instruction memory model for the core testbench.
 * Grants requests after a random delay and returns the addressed word
 * after a random latency, strictly in request order. The program image
 * is written into mem by the testbench before reset is released.
 */

`timescale 1ns/100ps
`default_nettype none

module imem_responder
    import core_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            instr_req_i,
    input  logic [xlen-1:0] instr_addr_i,
    output logic            instr_gnt_o,
    output logic            instr_rvalid_o,
    output logic [ilen-1:0] instr_rdata_o,
    output int              outstanding_o,
    output int              accepted_o,
    output int              answered_o
);

    localparam int mem_words = 256;
    localparam int gnt_max   = 3;
    localparam int rsp_min   = 1;
    localparam int rsp_max   = 4;

    // program image, indexed by address bits 9 to 2
    logic [ilen-1:0] mem [mem_words];

    logic [ilen-1:0] rsp_word_q [$];
    int              rsp_due_q  [$];
    logic            req_seen;
    logic [xlen-1:0] addr_seen;
    logic            in_reset;
    logic            gnt_pending;
    int              gnt_wait;
    int              cycle;

    initial begin
        instr_gnt_o    = 1'b0;
        instr_rvalid_o = 1'b0;
        instr_rdata_o  = '0;
        outstanding_o  = 0;
        accepted_o     = 0;
        answered_o     = 0;
        req_seen       = 1'b0;
        addr_seen      = '0;
        gnt_pending    = 1'b0;
        gnt_wait       = 0;
        cycle          = 0;
        forever begin
            @(posedge clk_i);
            in_reset = !rst_n_i;
            #1;
            cycle = cycle + 1;
            if (in_reset) begin
                rsp_word_q.delete();
                rsp_due_q.delete();
                instr_gnt_o    = 1'b0;
                instr_rvalid_o = 1'b0;
                instr_rdata_o  = '0;
                req_seen       = 1'b0;
                gnt_pending    = 1'b0;
                accepted_o     = 0;
                answered_o     = 0;
                outstanding_o  = 0;
            end else begin
                // handshake and response of the cycle that just ended
                if (instr_gnt_o && req_seen) begin
                    accepted_o = accepted_o + 1;
                    rsp_word_q.push_back(mem[addr_seen[9:2]]);
                    rsp_due_q.push_back(cycle - 1 + $urandom_range(rsp_max, rsp_min));
                end
                if (instr_rvalid_o) begin
                    answered_o = answered_o + 1;
                end
                outstanding_o = accepted_o - answered_o;

                req_seen    = instr_req_i;
                addr_seen   = instr_addr_i;
                instr_gnt_o = 1'b0;
                if (req_seen) begin
                    if (!gnt_pending) begin
                        gnt_wait    = $urandom_range(gnt_max, 0);
                        gnt_pending = 1'b1;
                    end
                    if (gnt_wait == 0) begin
                        instr_gnt_o = 1'b1;
                        gnt_pending = 1'b0;
                    end else begin
                        gnt_wait = gnt_wait - 1;
                    end
                end

                // at most one response per cycle, oldest first
                if ((rsp_due_q.size() > 0) && (rsp_due_q[0] <= cycle)) begin
                    instr_rvalid_o = 1'b1;
                    instr_rdata_o  = rsp_word_q.pop_front();
                    void'(rsp_due_q.pop_front());
                end else begin
                    instr_rvalid_o = 1'b0;
                    instr_rdata_o  = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/core_tb.sv ====
/*
 * Testbench of the minimal integer core.
 * Loads a random program into the memory model, runs it under random
 * grant and response delays and checks every commit against a model
 * of the supported RV32I subset. Build and run with run_sim.sh.
 */

`timescale 1ns/100ps
`default_nettype none

module core_tb
    import core_pkg::*;
();

    localparam int prog_words     = 256;
    localparam int commit_target  = 200;
    localparam int timeout_cycles = 2000;
    localparam int quiet_cycles   = 20;

    logic                  clk_i = 1'b0;
    logic                  rst_n_i;
    logic                  fetch_enable_i;
    logic [xlen-1:0]       boot_addr_i;
    logic                  instr_req_o;
    logic [xlen-1:0]       instr_addr_o;
    logic                  instr_gnt_i;
    logic                  instr_rvalid_i;
    logic [ilen-1:0]       instr_rdata_i;
    logic                  commit_valid_o;
    logic [xlen-1:0]       commit_pc_o;
    logic [reg_addr_w-1:0] commit_rd_o;
    logic [xlen-1:0]       commit_wdata_o;
    logic                  core_busy_o;
    int                    outstanding;
    int                    accepted;
    int                    answered;

    logic [ilen-1:0]       prog [prog_words];
    logic [xlen-1:0]       model_regs [nregs];
    logic [xlen-1:0]       boot_addr;
    logic [xlen-1:0]       req_addr_prev;
    logic                  req_waiting;
    logic                  run_ok;
    int                    commits;
    int                    requests;
    int                    drop_limit;
    int                    errors;
    int                    timeouts;

    always #2 clk_i = ~clk_i;

    core_top i_dut (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .boot_addr_i    ( boot_addr_i    ),
        .instr_req_o    ( instr_req_o    ),
        .instr_addr_o   ( instr_addr_o   ),
        .instr_gnt_i    ( instr_gnt_i    ),
        .instr_rvalid_i ( instr_rvalid_i ),
        .instr_rdata_i  ( instr_rdata_i  ),
        .commit_valid_o ( commit_valid_o ),
        .commit_pc_o    ( commit_pc_o    ),
        .commit_rd_o    ( commit_rd_o    ),
        .commit_wdata_o ( commit_wdata_o ),
        .core_busy_o    ( core_busy_o    )
    );

    imem_responder i_imem (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .instr_req_i    ( instr_req_o    ),
        .instr_addr_i   ( instr_addr_o   ),
        .instr_gnt_o    ( instr_gnt_i    ),
        .instr_rvalid_o ( instr_rvalid_i ),
        .instr_rdata_o  ( instr_rdata_i  ),
        .outstanding_o  ( outstanding    ),
        .accepted_o     ( accepted       ),
        .answered_o     ( answered       )
    );

    function automatic logic [reg_addr_w-1:0] pick_reg();
        // small register set so that results are read back often
        return reg_addr_w'($urandom_range(7, 0));
    endfunction

    function automatic logic [ilen-1:0] encode_reg_op(input logic [6:0] f7,
                                                      input logic [2:0] f3);
        return {f7, pick_reg(), pick_reg(), f3, pick_reg(), opc_op};
    endfunction

    function automatic logic [ilen-1:0] encode_imm_op(input logic [2:0] f3);
        return {12'($urandom), pick_reg(), f3, pick_reg(), opc_op_imm};
    endfunction

    task automatic build_program();
        logic [ilen-1:0] word;
        logic [2:0]      f3;
        int unsigned     kind;
        int              i;
        for (i = 0; i < prog_words; i++) begin
            if ($urandom_range(7, 0) == 0) begin
                word = $urandom;
                // move the opcode off the two supported ones
                if ((word[6:0] == opc_op) || (word[6:0] == opc_op_imm)) begin
                    word[2] = 1'b1;
                end
            end else begin
                // 0 to 4 register forms with 1 as SUB, 5 to 8 immediate forms
                kind = $urandom_range(8, 0);
                case (kind)
                    0, 1, 5: f3 = f3_add;
                    2, 6:    f3 = f3_xor;
                    3, 7:    f3 = f3_or;
                    default: f3 = f3_and;
                endcase
                if (kind < 5) begin
                    word = encode_reg_op((kind == 1) ? f7_sub : 7'b0, f3);
                end else begin
                    word = encode_imm_op(f3);
                end
            end
            prog[i]         = word;
            i_imem.mem[i] = word;
        end
    endtask

    // executes one word on the model registers and predicts the trace
    task automatic model_step(input logic [ilen-1:0] word,
                              output logic [reg_addr_w-1:0] exp_rd,
                              output logic [xlen-1:0] exp_wdata);
        logic [reg_addr_w-1:0] rd;
        logic [2:0]            f3;
        logic [6:0]            f7;
        logic [xlen-1:0]       a;
        logic [xlen-1:0]       b;
        logic [xlen-1:0]       res;
        logic                  ok;
        rd  = word[11:7];
        f3  = word[14:12];
        f7  = word[31:25];
        a   = model_regs[word[19:15]];
        b   = '0;
        res = '0;
        ok  = 1'b0;
        if (word[6:0] == opc_op) begin
            b = model_regs[word[24:20]];
            if ((f7 == f7_sub) && (f3 == f3_add)) begin
                ok  = 1'b1;
                res = a - b;
            end else if (f7 == 7'b0) begin
                ok = 1'b1;
            end
        end else if (word[6:0] == opc_op_imm) begin
            b  = {{(xlen-12){word[31]}}, word[31:20]};
            ok = 1'b1;
        end
        if (ok && !((word[6:0] == opc_op) && (f7 == f7_sub))) begin
            case (f3)
                f3_add:  res = a + b;
                f3_xor:  res = a ^ b;
                f3_or:   res = a | b;
                f3_and:  res = a & b;
                default: ok = 1'b0;
            endcase
        end
        exp_rd    = ok ? rd : '0;
        exp_wdata = '0;
        if (ok && (rd != '0)) begin
            model_regs[rd] = res;
            exp_wdata      = res;
        end
    endtask

    task automatic check_commit();
        logic [xlen-1:0]       exp_pc;
        logic [reg_addr_w-1:0] exp_rd;
        logic [xlen-1:0]       exp_wdata;
        exp_pc = boot_addr + xlen'(4 * commits);
        model_step(prog[exp_pc[9:2]], exp_rd, exp_wdata);
        commits = commits + 1;
        assert (commit_pc_o == exp_pc) else begin
            errors++;
            $display("[FAIL] commit_pc_o: got %h, expected %h", commit_pc_o, exp_pc);
        end
        assert (commit_rd_o == exp_rd) else begin
            errors++;
            $display("[FAIL] commit_rd_o at pc %h: got %h, expected %h",
                     exp_pc, commit_rd_o, exp_rd);
        end
        assert (commit_wdata_o == exp_wdata) else begin
            errors++;
            $display("[FAIL] commit_wdata_o at pc %h: got %h, expected %h",
                     exp_pc, commit_wdata_o, exp_wdata);
        end
    endtask

    task automatic check_fetch_port();
        if (req_waiting) begin
            assert (instr_req_o) else begin
                errors++;
                $display("[FAIL] instr_req_o dropped before grant: got %h, expected %h",
                         instr_req_o, 1'b1);
            end
            assert (instr_addr_o == req_addr_prev) else begin
                errors++;
                $display("[FAIL] instr_addr_o changed before grant: got %h, expected %h",
                         instr_addr_o, req_addr_prev);
            end
        end
        if (instr_req_o && instr_gnt_i) begin
            assert (instr_addr_o == boot_addr + xlen'(4 * requests)) else begin
                errors++;
                $display("[FAIL] instr_addr_o: got %h, expected %h",
                         instr_addr_o, boot_addr + xlen'(4 * requests));
            end
            requests = requests + 1;
        end
        req_waiting   = instr_req_o && !instr_gnt_i;
        req_addr_prev = instr_addr_o;
        assert (outstanding <= fifo_depth) else begin
            errors++;
            $display("[FAIL] outstanding requests: got %h, expected at most %h",
                     outstanding, fifo_depth);
        end
    endtask

    task automatic run_monitor();
        forever begin
            @(negedge clk_i);
            if (rst_n_i) begin
                if (commit_valid_o) begin
                    check_commit();
                end
                check_fetch_port();
            end
        end
    endtask

    task automatic check_quiet(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk_i);
            assert (!instr_req_o) else begin
                errors++;
                $display("[FAIL] instr_req_o while idle: got %h, expected %h",
                         instr_req_o, 1'b0);
            end
            assert (!commit_valid_o) else begin
                errors++;
                $display("[FAIL] commit_valid_o while idle: got %h, expected %h",
                         commit_valid_o, 1'b0);
            end
            assert (!core_busy_o) else begin
                errors++;
                $display("[FAIL] core_busy_o while idle: got %h, expected %h",
                         core_busy_o, 1'b0);
            end
        end
    endtask

    task automatic wait_for_commits(input int target, output logic ok);
        int n;
        n = 0;
        while ((commits < target) && (n < timeout_cycles)) begin
            @(posedge clk_i);
            n++;
        end
        ok = (commits >= target);
        if (!ok) begin
            timeouts++;
            $display("timeout: only %0d of %0d commits after %0d cycles",
                     commits, target, timeout_cycles);
        end
    endtask

    task automatic wait_for_idle(output logic ok);
        int n;
        n = 0;
        while (core_busy_o && (n < timeout_cycles)) begin
            @(negedge clk_i);
            n++;
        end
        ok = !core_busy_o;
        if (!ok) begin
            timeouts++;
            $display("timeout: core_busy_o still high %0d cycles after fetch enable fell",
                     timeout_cycles);
        end
    endtask

    initial begin
        void'($urandom(8));
        rst_n_i        = 1'b0;
        fetch_enable_i = 1'b0;
        errors         = 0;
        timeouts       = 0;
        commits        = 0;
        requests       = 0;
        drop_limit     = 0;
        req_waiting    = 1'b0;
        req_addr_prev  = '0;
        for (int r = 0; r < nregs; r++) begin
            model_regs[r] = '0;
        end
        boot_addr = $urandom & 32'hffff_fffc;
        if (boot_addr == '0) begin
            boot_addr = 32'h0000_0100;
        end
        boot_addr_i = boot_addr;
        build_program();
        fork
            run_monitor();
        join_none

        repeat (16) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        check_quiet(quiet_cycles);

        @(posedge clk_i);
        #1;
        fetch_enable_i = 1'b1;
        wait_for_commits(commit_target, run_ok);
        if (run_ok) begin
            @(posedge clk_i);
            #1;
            fetch_enable_i = 1'b0;
            // a request raised at this edge still waits for its grant
            drop_limit = requests + (instr_req_o ? 1 : 0);
            wait_for_idle(run_ok);
        end
        if (run_ok) begin
            // no response may still be owed once the core reports idle
            assert (answered == accepted) else begin
                errors++;
                $display("[FAIL] response count: got %h, expected %h", answered, accepted);
            end
            check_quiet(quiet_cycles);
            // every accepted request retired exactly once
            assert (commits == accepted) else begin
                errors++;
                $display("[FAIL] commit count: got %h, expected %h", commits, accepted);
            end
            assert (requests == drop_limit) else begin
                errors++;
                $display("[FAIL] instr_req_o accepted after fetch enable fell: got %h, expected %h",
                         requests, drop_limit);
            end
        end

        $display("%0d commits checked, %0d check errors, %0d timeouts",
                 commits, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/core_pkg.sv
design/instr_fetch.sv
design/fetch_fifo.sv
design/reg_file.sv
design/alu_exec.sv
design/core_top.sv
dv/imem_responder.sv
dv/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the core testbench with Verilator, runs it into sim.log and
# scans the log for the failure message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module core_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vcore_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

exit 0
